// ==== source/apb_subsys_settings.svh ====
/* Build-time settings of the APB subsystem: bus widths, slot map, FIFO depth and
   register offsets. Included by the package and by every module that needs a value */

`ifndef APB_SUBSYS_SETTINGS_SVH
`define APB_SUBSYS_SETTINGS_SVH

// --------------------
// Bus widths
`define APB_SUBSYS_HADDR_W        16  // AHB address bits
`define APB_SUBSYS_DATA_W         32  // AHB and APB data bits
`define APB_SUBSYS_SLOT_W         4   // Slot field HADDR[15:12]
`define APB_SUBSYS_POFS_W         10  // Word offset PADDR[11:2]

// --------------------
// Peripheral map
`define APB_SUBSYS_COMMFIFO_SLOT  3
`define APB_SUBSYS_FIFO_DEPTH     8   // Entries per byte queue
`define APB_SUBSYS_REG_DATA       0   // Word offsets inside the slot
`define APB_SUBSYS_REG_STATUS     1

`define APB_SUBSYS_BIG_ENDIAN     1   // 1 = big-endian processor bus

`endif

// ==== source/apb_subsys_pkg.sv ====
/* Shared types of the APB subsystem. Modules pull them in with a wildcard import */

`default_nettype none

`include "apb_subsys_settings.svh"

package apb_subsys_pkg;

  typedef logic [`APB_SUBSYS_HADDR_W-1:0] haddr_t;     // AHB address
  typedef logic [`APB_SUBSYS_DATA_W-1:0]  bus_data_t;  // Bus word
  typedef logic [`APB_SUBSYS_SLOT_W-1:0]  slot_t;      // Peripheral slot number
  typedef logic [`APB_SUBSYS_POFS_W-1:0]  poffset_t;   // Word offset in a slot
  typedef logic [7:0]                     fifo_byte_t; // One queue entry
  typedef logic [1:0]                     swap_ctrl_t; // [1] half-words, [0] bytes

  // Bridge FSM, one AHB transfer at a time
  typedef enum logic [2:0] {
    st_idle, st_sample, st_setup, st_access, st_done, st_err1, st_err2
  } bridge_state_t;

endpackage

`default_nettype wire

// ==== source/ahb_byte_lane_swap.sv ====
/* Byte-lane swap between a big-endian AHB master and the little-endian APB side.
   Swap control is captured with the address and held for the data phase */

`timescale 1ns/100ps
`default_nettype none

module ahb_byte_lane_swap
  import apb_subsys_pkg::*;
#(
  parameter int p_big_endian = 1
) (
  input  wire        i_hclk,
  input  wire        i_hresetn,
  input  wire        i_addr_valid, // Transfer accepted this cycle
  input  wire  [2:0] i_hsize,
  input  bus_data_t  i_hwdata,     // Write data from the master
  input  bus_data_t  i_rdata_le,   // Read data from the bridge
  output bus_data_t  o_wdata_le,
  output bus_data_t  o_hrdata
);

  localparam logic lc_big = (p_big_endian != 0);

  swap_ctrl_t ctrl_d;
  swap_ctrl_t ctrl_q; // Held for the whole data phase

  // Bytes within each half first, then the halves
  function automatic bus_data_t lane_swap(input bus_data_t d, input swap_ctrl_t c);
    bus_data_t b;
    b = c[0] ? {d[23:16], d[31:24], d[7:0], d[15:8]} : d;
    return c[1] ? {b[15:0], b[31:16]} : b;
  endfunction

  assign ctrl_d[1] = lc_big & (i_hsize == 3'b010);                        // Word
  assign ctrl_d[0] = lc_big & ((i_hsize == 3'b001) | (i_hsize == 3'b010)); // Half or word

  always_ff @(posedge i_hclk or negedge i_hresetn)
  begin
    if (!i_hresetn)
      ctrl_q <= '0;
    else if (i_addr_valid)
      ctrl_q <= ctrl_d;
  end

  assign o_wdata_le = lane_swap(i_hwdata, ctrl_q);
  assign o_hrdata   = lane_swap(i_rdata_le, ctrl_q); // Same mapping both ways

endmodule

`default_nettype wire

// ==== source/ahb_apb_bridge.sv ====
/* AHB to APB bridge. Each accepted AHB transfer becomes one APB setup and access
   pair; AHB wait states cover the APB transfer and PSLVERR maps to an ERROR response */

`timescale 1ns/100ps
`default_nettype none

module ahb_apb_bridge
  import apb_subsys_pkg::*;
(
  input  wire        i_hclk,
  input  wire        i_hresetn,
  // AHB slave side
  input  wire        i_hsel,
  input  haddr_t     i_haddr,
  input  wire  [1:0] i_htrans,
  input  wire        i_hwrite,
  input  wire        i_hready,
  input  bus_data_t  i_hwdata,    // Already in little-endian lanes
  output logic       o_hreadyout,
  output bus_data_t  o_hrdata,
  output logic       o_hresp,
  output logic       o_addr_valid, // Acceptance strobe for the lane swap
  // APB master side
  output haddr_t     o_paddr,
  output logic       o_psel,
  output logic       o_penable,
  output logic       o_pwrite,
  output bus_data_t  o_pwdata,
  input  bus_data_t  i_prdata,
  input  wire        i_pready,
  input  wire        i_pslverr
);

  bridge_state_t state_q;
  bridge_state_t state_d;
  logic          accept;
  logic          apb_done; // Access cycle ends this clock
  haddr_t        addr_q;
  logic          write_q;
  bus_data_t     wdata_q;
  bus_data_t     rdata_q;

  // NONSEQ or SEQ with the bus ready
  assign accept   = i_hsel & i_htrans[1] & i_hready;
  assign apb_done = (state_q == st_access) & i_pready;

  // --------------------
  // FSM
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle, st_done, st_err2: // Free to take the next address phase
      begin
        if (accept)
          state_d = st_sample;
        else
          state_d = st_idle;
      end
      st_sample: state_d = st_setup;   // HWDATA valid here
      st_setup:  state_d = st_access;
      st_access:
      begin
        if (i_pready)
          state_d = i_pslverr ? st_err1 : st_done;
      end
      st_err1:   state_d = st_err2;    // Two-cycle ERROR
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_hresetn)
  begin
    if (!i_hresetn)
    begin
      state_q <= st_idle;
      addr_q  <= '0;
      write_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept && (state_q == st_idle || state_q == st_done || state_q == st_err2))
      begin
        addr_q  <= i_haddr;  // Address and direction of the new transfer
        write_q <= i_hwrite;
      end
    end
  end

  // --------------------
  // Data registers
  always_ff @(posedge i_hclk)
  begin
    if (state_q == st_sample)
      wdata_q <= i_hwdata;
    if (apb_done)
      rdata_q <= i_prdata;   // Presented in st_done
  end

  assign o_addr_valid = accept;
  assign o_hreadyout  = (state_q == st_idle) | (state_q == st_done) | (state_q == st_err2);
  assign o_hresp      = (state_q == st_err1) | (state_q == st_err2);
  assign o_hrdata     = rdata_q;

  assign o_paddr   = addr_q;
  assign o_psel    = (state_q == st_setup) | (state_q == st_access);
  assign o_penable = (state_q == st_access);
  assign o_pwrite  = write_q;
  assign o_pwdata  = wdata_q;

endmodule

`default_nettype wire

// ==== source/apb_slave_mux.sv ====
/* APB slave multiplexer over sixteen slots decoded from address bits 15:12.
   Only the communication FIFO slot is populated; every other slot answers ERROR */

`timescale 1ns/100ps
`default_nettype none

`include "apb_subsys_settings.svh"

module apb_slave_mux
  import apb_subsys_pkg::*;
(
  input  haddr_t     i_paddr,
  input  wire        i_psel,
  // Communication FIFO slot
  output logic       o_comm_psel,
  input  bus_data_t  i_comm_prdata,
  input  wire        i_comm_pready,
  input  wire        i_comm_pslverr,
  // Back to the bridge
  output bus_data_t  o_prdata,
  output logic       o_pready,
  output logic       o_pslverr
);

  slot_t slot;
  logic  hit_comm;

  assign slot     = i_paddr[`APB_SUBSYS_HADDR_W-1 -: `APB_SUBSYS_SLOT_W];
  assign hit_comm = (slot == slot_t'(`APB_SUBSYS_COMMFIFO_SLOT));

  assign o_comm_psel = i_psel & hit_comm;

  // Empty slot: ready at once, error, zero data
  assign o_prdata  = hit_comm ? i_comm_prdata : '0;
  assign o_pready  = hit_comm ? i_comm_pready : 1'b1;
  assign o_pslverr = hit_comm ? i_comm_pslverr : 1'b1;

endmodule

`default_nettype wire

// ==== source/sync_byte_fifo.sv ====
/* Single-clock byte FIFO, circular buffer with an entry count. The head entry
   is visible without a pop; an empty FIFO shows zero */

`timescale 1ns/100ps
`default_nettype none

module sync_byte_fifo
  import apb_subsys_pkg::*;
#(
  parameter int p_depth = 8
) (
  input  wire         i_hclk,
  input  wire         i_hresetn,
  input  wire         i_push,
  input  fifo_byte_t  i_data,
  input  wire         i_pop,
  output fifo_byte_t  o_head,  // Show-ahead
  output logic        o_full,
  output logic        o_empty
);

  localparam int lc_ptr_w = (p_depth > 1) ? $clog2(p_depth) : 1;
  localparam int lc_cnt_w = $clog2(p_depth + 1);

  fifo_byte_t            mem [p_depth];
  logic [lc_ptr_w-1:0]   wr_ptr;
  logic [lc_ptr_w-1:0]   rd_ptr;
  logic [lc_cnt_w-1:0]   count;
  logic                  do_push; // Push to full is dropped
  logic                  do_pop;  // Pop from empty is ignored

  assign do_push = i_push & ~o_full;
  assign do_pop  = i_pop & ~o_empty;

  always_ff @(posedge i_hclk or negedge i_hresetn)
  begin
    if (!i_hresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == lc_ptr_w'(p_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == lc_ptr_w'(p_depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  // Storage
  always_ff @(posedge i_hclk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_data;
  end

  assign o_full  = (count == lc_cnt_w'(p_depth));
  assign o_empty = (count == '0);
  assign o_head  = o_empty ? '0 : mem[rd_ptr];

endmodule

`default_nettype wire

// ==== source/host_comm_fifo.sv ====
/* Host communication FIFO as an APB slave. DATA reads pop the host-to-device queue,
   DATA writes push the device-to-host queue; STATUS shows the queue levels */

`timescale 1ns/100ps
`default_nettype none

`include "apb_subsys_settings.svh"

module host_comm_fifo
  import apb_subsys_pkg::*;
(
  input  wire         i_hclk,
  input  wire         i_hresetn,
  // APB slave
  input  wire         i_psel,
  input  wire         i_penable,
  input  wire         i_pwrite,
  input  poffset_t    i_poffset,
  input  bus_data_t   i_pwdata,
  output bus_data_t   o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  // Host side
  input  wire         i_h2d_write,
  input  fifo_byte_t  i_h2d_data,
  output logic        o_h2d_not_full,
  output logic        o_d2h_not_empty,
  input  wire         i_d2h_rd,
  output fifo_byte_t  o_d2h_data
);

  logic       access;     // APB access cycle
  logic       sel_data;
  logic       sel_status;
  logic       h2d_pop;
  logic       d2h_push;
  fifo_byte_t h2d_head;
  logic       h2d_full;
  logic       h2d_empty;
  logic       d2h_full;
  logic       d2h_empty;

  assign access     = i_psel & i_penable;
  assign sel_data   = (i_poffset == poffset_t'(`APB_SUBSYS_REG_DATA));
  assign sel_status = (i_poffset == poffset_t'(`APB_SUBSYS_REG_STATUS));

  assign h2d_pop  = access & ~i_pwrite & sel_data; // Read of DATA consumes the head
  assign d2h_push = access & i_pwrite & sel_data;

  // --------------------
  // Queues
  sync_byte_fifo #(.p_depth(`APB_SUBSYS_FIFO_DEPTH)) u_h2d (
    .i_hclk    (i_hclk),
    .i_hresetn (i_hresetn),
    .i_push    (i_h2d_write),
    .i_data    (i_h2d_data),
    .i_pop     (h2d_pop),
    .o_head    (h2d_head),
    .o_full    (h2d_full),
    .o_empty   (h2d_empty)
  );

  sync_byte_fifo #(.p_depth(`APB_SUBSYS_FIFO_DEPTH)) u_d2h (
    .i_hclk    (i_hclk),
    .i_hresetn (i_hresetn),
    .i_push    (d2h_push),
    .i_data    (i_pwdata[7:0]),  // Low byte only
    .i_pop     (i_d2h_rd),
    .o_head    (o_d2h_data),
    .o_full    (d2h_full),
    .o_empty   (d2h_empty)
  );

  // Read mux
  always_comb
  begin
    o_prdata = '0;
    if (sel_data)
      o_prdata[7:0] = h2d_head;
    else if (sel_status)
      o_prdata[1:0] = {~d2h_full, ~h2d_empty}; // [1] d2h room, [0] h2d data
  end

  assign o_pready  = 1'b1;                      // No wait states
  assign o_pslverr = ~(sel_data | sel_status);  // Unmapped offset

  assign o_h2d_not_full  = ~h2d_full;
  assign o_d2h_not_empty = ~d2h_empty;

endmodule

`default_nettype wire

// ==== source/apb_subsys.sv ====
/* APB subsystem top level: lane swap, AHB to APB bridge, slot multiplexer and the
   host communication FIFO at slot 3, all on one clock */

`timescale 1ns/100ps
`default_nettype none

`include "apb_subsys_settings.svh"

module apb_subsys
  import apb_subsys_pkg::*;
#(
  parameter int p_big_endian = `APB_SUBSYS_BIG_ENDIAN
) (
  input  wire         i_hclk,
  input  wire         i_hresetn,
  // AHB slave port
  input  wire         i_hsel,
  input  haddr_t      i_haddr,
  input  wire  [1:0]  i_htrans,
  input  wire         i_hwrite,
  input  wire  [2:0]  i_hsize,
  input  wire         i_hready,
  input  bus_data_t   i_hwdata,
  output logic        o_hreadyout,
  output bus_data_t   o_hrdata,
  output logic        o_hresp,
  // Host port of the communication FIFO
  input  wire         i_h2d_write,
  input  fifo_byte_t  i_h2d_data,
  output logic        o_h2d_not_full,
  output logic        o_d2h_not_empty,
  input  wire         i_d2h_rd,
  output fifo_byte_t  o_d2h_data
);

  logic      addr_valid;
  bus_data_t hwdata_le;  // Little-endian write data
  bus_data_t hrdata_le;  // Little-endian read data

  // APB request
  haddr_t    paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  bus_data_t pwdata;

  // --------------------
  // APB response
  bus_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      comm_psel;
  bus_data_t comm_prdata;
  logic      comm_pready;
  logic      comm_pslverr;

  ahb_byte_lane_swap #(.p_big_endian(p_big_endian)) u_swap (
    .i_hclk       (i_hclk),
    .i_hresetn    (i_hresetn),
    .i_addr_valid (addr_valid),
    .i_hsize      (i_hsize),
    .i_hwdata     (i_hwdata),
    .i_rdata_le   (hrdata_le),
    .o_wdata_le   (hwdata_le),
    .o_hrdata     (o_hrdata)
  );

  ahb_apb_bridge u_bridge (
    .i_hclk       (i_hclk),
    .i_hresetn    (i_hresetn),
    .i_hsel       (i_hsel),
    .i_haddr      (i_haddr),
    .i_htrans     (i_htrans),
    .i_hwrite     (i_hwrite),
    .i_hready     (i_hready),
    .i_hwdata     (hwdata_le),
    .o_hreadyout  (o_hreadyout),
    .o_hrdata     (hrdata_le),
    .o_hresp      (o_hresp),
    .o_addr_valid (addr_valid),
    .o_paddr      (paddr),
    .o_psel       (psel),
    .o_penable    (penable),
    .o_pwrite     (pwrite),
    .o_pwdata     (pwdata),
    .i_prdata     (prdata),
    .i_pready     (pready),
    .i_pslverr    (pslverr)
  );

  apb_slave_mux u_mux (
    .i_paddr        (paddr),
    .i_psel         (psel),
    .o_comm_psel    (comm_psel),
    .i_comm_prdata  (comm_prdata),
    .i_comm_pready  (comm_pready),
    .i_comm_pslverr (comm_pslverr),
    .o_prdata       (prdata),
    .o_pready       (pready),
    .o_pslverr      (pslverr)
  );

  host_comm_fifo u_commfifo (
    .i_hclk          (i_hclk),
    .i_hresetn       (i_hresetn),
    .i_psel          (comm_psel),
    .i_penable       (penable),
    .i_pwrite        (pwrite),
    .i_poffset       (paddr[`APB_SUBSYS_POFS_W+1:2]), // Word offset in slot
    .i_pwdata        (pwdata),
    .o_prdata        (comm_prdata),
    .o_pready        (comm_pready),
    .o_pslverr       (comm_pslverr),
    .i_h2d_write     (i_h2d_write),
    .i_h2d_data      (i_h2d_data),
    .o_h2d_not_full  (o_h2d_not_full),
    .o_d2h_not_empty (o_d2h_not_empty),
    .i_d2h_rd        (i_d2h_rd),
    .o_d2h_data      (o_d2h_data)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
/* Clock and reset source of the testbench. HCLK runs free from time zero and
   HRESETn is held low for the first cycles, released just after a rising edge */

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int p_period       = 8,  // ns
  parameter int p_reset_cycles = 5
) (
  output logic o_hclk,
  output logic o_hresetn
);

  initial
  begin
    o_hclk = 1'b0;
    forever #(p_period / 2) o_hclk = ~o_hclk;
  end

  // Release off the edge, like the other stimulus
  initial
  begin
    o_hresetn = 1'b0;
    repeat (p_reset_cycles) @(posedge o_hclk);
    #1 o_hresetn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/apb_subsys_props.sv ====
/* APB phase properties of the bridge. Bound into ahb_apb_bridge
   from the testbench top, one instance per bridge */

`timescale 1ns/100ps
`default_nettype none

module apb_subsys_props (
  input wire i_hclk,
  input wire i_hresetn,
  input wire i_psel,
  input wire i_penable
);

  // --------------------
  // APB phases
  penable_in_psel: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    i_penable |-> i_psel)
    else $error("PENABLE high while PSEL is low");

  setup_before_access: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    $rose(i_psel) |-> !i_penable)
    else $error("PSEL and PENABLE rose in the same cycle");

  access_after_setup: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    $rose(i_psel) |=> i_penable)
    else $error("No access cycle after the APB setup cycle");

endmodule

`default_nettype wire

// ==== bench/apb_subsys_tb.sv ====
/* Testbench of the APB subsystem. Steps through the pattern file, drives the AHB
   master and host ports, and compares each response with the value in the file */

`timescale 1ns/100ps
`default_nettype none

module apb_subsys_tb;

  localparam int c_period    = 8;   // ns
  localparam int c_max_steps = 64;
  localparam int c_fields    = 5;   // Words per pattern line
  localparam int c_step_time = 20;  // Cycles allowed per step

  logic        hclk;
  logic        hresetn;
  logic        hsel;
  logic [15:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [2:0]  hsize;
  logic        hready;
  logic [31:0] hwdata;
  logic        o_hreadyout;
  logic [31:0] o_hrdata;
  logic        o_hresp;
  logic        h2d_write;
  logic [7:0]  h2d_data;
  logic        o_h2d_not_full;
  logic        o_d2h_not_empty;
  logic        d2h_rd;
  logic [7:0]  o_d2h_data;

  logic [31:0] pat_mem [c_max_steps*c_fields];
  int          n_steps;
  bit          steps_ready;
  int          errors;
  int          checks;

  tb_clock_gen #(.p_period(c_period), .p_reset_cycles(5)) u_clock_gen (
    .o_hclk    (hclk),
    .o_hresetn (hresetn)
  );

  apb_subsys #(.p_big_endian(1)) apb_subsys_i (
    .i_hclk          (hclk),
    .i_hresetn       (hresetn),
    .i_hsel          (hsel),
    .i_haddr         (haddr),
    .i_htrans        (htrans),
    .i_hwrite        (hwrite),
    .i_hsize         (hsize),
    .i_hready        (hready),
    .i_hwdata        (hwdata),
    .o_hreadyout     (o_hreadyout),
    .o_hrdata        (o_hrdata),
    .o_hresp         (o_hresp),
    .i_h2d_write     (h2d_write),
    .i_h2d_data      (h2d_data),
    .o_h2d_not_full  (o_h2d_not_full),
    .o_d2h_not_empty (o_d2h_not_empty),
    .i_d2h_rd        (d2h_rd),
    .o_d2h_data      (o_d2h_data)
  );

  bind ahb_apb_bridge apb_subsys_props u_props (
    .i_hclk    (i_hclk),
    .i_hresetn (i_hresetn),
    .i_psel    (o_psel),
    .i_penable (o_penable)
  );

  // --------------------
  // Checks and bus tasks
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  // One NONSEQ transfer with address phase then data phase until HREADYOUT
  task automatic ahb_transfer(input logic wr, input logic [15:0] addr,
                              input logic [2:0] size, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic [1:0] resp);
    logic err_wait;
    err_wait = 1'b0;
    @(posedge hclk);
    #1;
    hsel   = 1'b1;
    htrans = 2'b10;   // NONSEQ
    haddr  = addr;
    hwrite = wr;
    hsize  = size;
    @(posedge hclk);
    #1;
    hsel   = 1'b0;
    htrans = 2'b00;   // IDLE behind it
    hwdata = wdata;
    while (!o_hreadyout)
    begin
      if (o_hresp)
        err_wait = 1'b1; // First ERROR cycle
      @(posedge hclk);
      #1;
    end
    rdata = o_hrdata;
    resp  = {err_wait, o_hresp};
  endtask

  task automatic push_host_byte(input logic [7:0] d);
    @(posedge hclk);
    #1;
    h2d_write = 1'b1;
    h2d_data  = d;
    @(posedge hclk);
    #1;
    h2d_write = 1'b0;
  endtask

  // Head is visible before the read strobe
  task automatic pop_host_byte(input string name, input logic [31:0] exp);
    @(posedge hclk);
    #1;
    check_value(name, exp, {24'h0, o_d2h_data});
    d2h_rd = 1'b1;
    @(posedge hclk);
    #1;
    d2h_rd = 1'b0;
  endtask

  task automatic check_flags(input string name, input logic [31:0] exp);
    @(posedge hclk);
    #1;
    check_value(name, exp, {28'h0, o_hresp, o_hreadyout, o_d2h_not_empty, o_h2d_not_full});
  endtask

  // One line of the pattern file
  task automatic run_step(input int step);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] size;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] rdata;
    logic [1:0]  resp;
    string       name;
    op   = pat_mem[step*c_fields];
    addr = pat_mem[step*c_fields+1];
    size = pat_mem[step*c_fields+2];
    data = pat_mem[step*c_fields+3];
    exp  = pat_mem[step*c_fields+4];
    name = $sformatf("step %0d op %0h addr %04h", step, op, addr[15:0]);
    case (op)
      32'h1:
      begin
        ahb_transfer(1'b1, addr[15:0], size[2:0], data, rdata, resp);
        check_value({name, " write response"}, exp, {30'h0, resp});
      end
      32'h2:
      begin
        ahb_transfer(1'b0, addr[15:0], size[2:0], data, rdata, resp);
        check_value({name, " read data"}, exp, rdata);
        check_value({name, " read response"}, 32'h0, {30'h0, resp});
      end
      32'h3:
      begin
        ahb_transfer(1'b0, addr[15:0], size[2:0], data, rdata, resp);
        check_value({name, " error response"}, exp, {30'h0, resp});
      end
      32'h4: push_host_byte(data[7:0]);
      32'h5: pop_host_byte({name, " host byte"}, exp);
      32'h6: check_flags({name, " flags"}, exp);
      default:
      begin
        errors++;
        $display("Pattern step %0d has an unknown operation %0h", step, op);
      end
    endcase
  endtask

  // --------------------
  // Main sequence
  initial
  begin
    hsel        = 1'b0;
    haddr       = '0;
    htrans      = 2'b00;
    hwrite      = 1'b0;
    hsize       = 3'b000;
    hready      = 1'b1;  // Single master keeps the bus ready
    hwdata      = '0;
    h2d_write   = 1'b0;
    h2d_data    = '0;
    d2h_rd      = 1'b0;
    errors      = 0;
    checks      = 0;
    n_steps     = 0;
    steps_ready = 1'b0;
    $readmemh("bench/apb_subsys_patterns.txt", pat_mem);
    while (n_steps < c_max_steps && !$isunknown(pat_mem[n_steps*c_fields])
           && pat_mem[n_steps*c_fields] != 32'h0)
      n_steps++;
    steps_ready = 1'b1;
    if (n_steps == 0)
    begin
      errors++;
      $display("The pattern file holds no steps");
    end
    wait (hresetn);
    for (int i = 0; i < n_steps; i++)
      run_step(i);
    @(posedge hclk);
    #1;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // Time budget from the number of steps plus reset
  initial
  begin
    wait (steps_ready);
    #(c_period * (n_steps * c_step_time + 5));
    $display("Simulation ran past the time allowed for %0d steps, errors so far: %0d",
             n_steps, errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/apb_subsys_pkg.sv
source/ahb_byte_lane_swap.sv
source/ahb_apb_bridge.sv
source/apb_slave_mux.sv
source/sync_byte_fifo.sv
source/host_comm_fifo.sv
source/apb_subsys.sv
bench/tb_clock_gen.sv
bench/apb_subsys_props.sv
bench/apb_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run of the APB subsystem testbench

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= apb_subsys_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := Test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q -e "$(FAIL_MSG)" -e "%Error" $(LOG); then echo "Simulation FAILED"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/apb_subsys_patterns.txt ====
// Columns (hex): op addr size data expected. op 1 AHB write, 2 AHB read, 3 AHB read
// with ERROR, 4 host push, 5 host pop, 6 flags {hresp,hreadyout,d2h_ne,h2d_nf}, 0 end
// Response code for op 1 and 3 is {hresp while waiting, hresp at completion}
6 0000 0 00000000 00000005
// Device to host, byte is HWDATA[31:24]
1 3000 2 A1B2C3D4 00000000
1 3000 2 11223344 00000000
6 0000 0 00000000 00000007
5 0000 0 00000000 000000A1
5 0000 0 00000000 00000011
// Host to device, byte lands in HRDATA[31:24]
4 0000 0 0000005A 00000000
4 0000 0 000000C3 00000000
2 3004 2 00000000 03000000
2 3000 2 00000000 5A000000
2 3000 2 00000000 C3000000
2 3004 2 00000000 02000000
// Unpopulated slot 5
3 5000 2 00000000 00000003
// Fill device to host queue, ninth write dropped
1 3000 2 01000000 00000000
1 3000 2 02000000 00000000
1 3000 2 03000000 00000000
1 3000 2 04000000 00000000
1 3000 2 05000000 00000000
1 3000 2 06000000 00000000
1 3000 2 07000000 00000000
1 3000 2 08000000 00000000
2 3004 2 00000000 00000000
1 3000 2 09000000 00000000
5 0000 0 00000000 00000001
5 0000 0 00000000 00000002
5 0000 0 00000000 00000003
5 0000 0 00000000 00000004
5 0000 0 00000000 00000005
5 0000 0 00000000 00000006
5 0000 0 00000000 00000007
5 0000 0 00000000 00000008
5 0000 0 00000000 00000000
6 0000 0 00000000 00000005
// Half-word STATUS read, bytes swapped in each half
2 3004 1 00000000 00000200
0 0000 0 00000000 00000000
